// ==== Makefile ====
TOP := pagerTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hw/accessCheck.sv ====
`timescale 1ns/1ps
module accessCheck (
  input  logic                      clk,
  input  logic                      rstN,
  ptRspIf.dst                       in,
  output logic                      rspValid,
  output logic                      pageOk,
  output logic                      pageRefill,
  output logic                      pageFail,
  output pagerPkg::pfCodeT          failCode,
  output logic [pagerPkg::ppnW-1:0] physPage,
  output logic                      cacheable
);
  import pagerPkg::*;

  logic okNext;
  logic refillNext;
  logic failNext;
  pfCodeT codeNext;
  logic [ppnW-1:0] pageNext;
  logic cacheNext;

  // Checks in priority order, exactly one outcome wins
  always_comb begin
    okNext = 1'b0;
    refillNext = 1'b0;
    failNext = 1'b0;
    codeNext = pfNone;
    pageNext = in.entry.ppn;
    cacheNext = 1'b0;
    if (!in.paged) begin
      okNext = 1'b1;
      pageNext = in.vpnLow;
    end else if (!in.hit) begin
      refillNext = 1'b1;
    end else if (!in.parOk) begin
      failNext = 1'b1;
      codeNext = pfParity;
    end else if (!in.entry.access) begin
      failNext = 1'b1;
      codeNext = pfNoAccess;
    end else if (in.user && !in.entry.public) begin
      failNext = 1'b1;
      codeNext = pfPrivate;
    end else if (in.write && !in.entry.writable) begin
      failNext = 1'b1;
      codeNext = pfWriteProt;
    end else begin
      okNext = 1'b1;
      cacheNext = in.entry.cache;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rspValid <= 1'b0;
      pageOk <= 1'b0;
      pageRefill <= 1'b0;
      pageFail <= 1'b0;
    end else begin
      rspValid <= in.valid;
      pageOk <= in.valid && okNext;
      pageRefill <= in.valid && refillNext;
      pageFail <= in.valid && failNext;
    end
  end

  // Result payload holds its last value between responses
  always_ff @(posedge clk) begin
    if (in.valid) begin
      failCode <= codeNext;
      physPage <= pageNext;
      cacheable <= cacheNext;
    end
  end

endmodule

// ==== hw/pager.sv ====
`timescale 1ns/1ps
module pager (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic                      reqValid,
  input  pagerPkg::ptOpT            reqOp,
  input  logic [pagerPkg::vpnW-1:0] vpn,
  input  logic                      user,
  input  logic                      write,
  input  logic                      paged,
  input  pagerPkg::ptLineT          refillLine,
  input  logic                      parForce,
  output logic                      rspValid,
  output logic                      pageOk,
  output logic                      pageRefill,
  output logic                      pageFail,
  output pagerPkg::pfCodeT          failCode,
  output logic [pagerPkg::ppnW-1:0] physPage,
  output logic                      cacheable
);

  ptReqIf reqBus ();
  ptRspIf rspBus ();

  // Stage 1, fold and register
  ptIndex uIndex (
    .clk        (clk),
    .rstN       (rstN),
    .reqValid   (reqValid),
    .reqOp      (reqOp),
    .vpn        (vpn),
    .user       (user),
    .write      (write),
    .paged      (paged),
    .refillLine (refillLine),
    .parForce   (parForce),
    .out        (reqBus.src)
  );

  // Stage 2, table access
  ptLookup uLookup (
    .clk  (clk),
    .rstN (rstN),
    .in   (reqBus.dst),
    .out  (rspBus.src)
  );

  // Stage 3, access rules
  accessCheck uCheck (
    .clk        (clk),
    .rstN       (rstN),
    .in         (rspBus.dst),
    .rspValid   (rspValid),
    .pageOk     (pageOk),
    .pageRefill (pageRefill),
    .pageFail   (pageFail),
    .failCode   (failCode),
    .physPage   (physPage),
    .cacheable  (cacheable)
  );

endmodule

// ==== hw/pagerPkg.sv ====
package pagerPkg;

  // Address and payload sizes
  localparam int vpnW = 14;
  localparam int ppnW = 13;
  localparam int ptIdxW = 8;
  localparam int tagW = 6;

  typedef enum logic [1:0] {
    opLookup = 2'd0,
    opRefill = 2'd1,
    opDirClr = 2'd2
  } ptOpT;

  typedef enum logic [2:0] {
    pfNone      = 3'd0,
    pfParity    = 3'd1,
    pfNoAccess  = 3'd2,
    pfPrivate   = 3'd3,
    pfWriteProt = 3'd4
  } pfCodeT;

  // One half word of a page-table line, access bit leftmost
  typedef struct packed {
    logic access;
    logic public;
    logic writable;
    logic software;
    logic cache;
    logic [ppnW-1:0] ppn;
  } ptHalfT;

  // Even vpn in the left half, odd vpn in the right half
  typedef struct packed {
    ptHalfT left;
    ptHalfT right;
  } ptLineT;

endpackage

// ==== hw/ptIndex.sv ====
`timescale 1ns/1ps
module ptIndex (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic                      reqValid,
  input  pagerPkg::ptOpT            reqOp,
  input  logic [pagerPkg::vpnW-1:0] vpn,
  input  logic                      user,
  input  logic                      write,
  input  logic                      paged,
  input  pagerPkg::ptLineT          refillLine,
  input  logic                      parForce,
  ptReqIf.src                       out
);
  import pagerPkg::*;

  logic [ptIdxW-1:0] idxNext;
  logic [tagW-1:0] tagNext;
  logic halfNext;

  // Fold the vpn into a line address
  // Exec and user space land on different lines through bit 6
  always_comb begin
    idxNext[7] = vpn[8];
    idxNext[6] = vpn[7] ^ ~user;
    idxNext[5] = vpn[6] ^ vpn[9];
    idxNext[4:0] = vpn[5:1];
    halfNext = vpn[0];
    tagNext = {user, vpn[13:9]};
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      out.valid <= 1'b0;
    end else begin
      out.valid <= reqValid;
    end
  end

  // Request fields, held while idle
  always_ff @(posedge clk) begin
    if (reqValid) begin
      out.op <= reqOp;
      out.index <= idxNext;
      out.half <= halfNext;
      out.tag <= tagNext;
      out.user <= user;
      out.write <= write;
      out.paged <= paged;
      out.line <= refillLine;
      out.parForce <= parForce;
    end
  end

endmodule

// ==== hw/ptLookup.sv ====
`timescale 1ns/1ps
module ptLookup (
  input  logic clk,
  input  logic rstN,
  ptReqIf.dst  in,
  ptRspIf.src  out
);
  import pagerPkg::*;

  ptLineT ptMem [2**ptIdxW];
  logic [tagW-1:0] tagMem [2**ptIdxW];
  // Left parity in bit 1, right parity in bit 0
  logic [1:0] parMem [2**ptIdxW];
  logic [2**ptIdxW-1:0] dirValid;

  // Request held for the table cycle
  logic curValid;
  ptOpT curOp;
  logic [ptIdxW-1:0] curIndex;
  logic curHalf;
  logic [tagW-1:0] curTag;
  logic curUser;
  logic curWrite;
  logic curPaged;
  ptLineT curLine;
  logic curParForce;

  // Read data and forwarded fields
  logic rdValid;
  ptLineT rdLine;
  logic [tagW-1:0] rdTag;
  logic [1:0] rdPar;
  logic rdDirValid;
  logic [tagW-1:0] rdReqTag;
  logic rdHalf;
  logic rdUser;
  logic rdWrite;
  logic rdPaged;
  logic [ppnW-1:0] rdVpnLow;

  logic [1:0] parNext;
  logic [ppnW-1:0] vpnLowNext;
  ptHalfT selHalf;
  logic selPar;

  // Odd parity per half, parForce stores it inverted
  always_comb begin
    parNext[1] = ~(^curLine.left) ^ curParForce;
    parNext[0] = ~(^curLine.right) ^ curParForce;
  end

  // Undo the address fold to recover the low vpn bits
  assign vpnLowNext = {curTag[3:0], curIndex[7], curIndex[6] ^ ~curUser,
                       curIndex[5] ^ curTag[0], curIndex[4:0], curHalf};

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      curValid <= 1'b0;
      rdValid <= 1'b0;
      dirValid <= '0;
    end else begin
      curValid <= in.valid;
      rdValid <= curValid && (curOp == opLookup);
      if (curValid && (curOp == opDirClr)) begin
        dirValid <= '0;
      end else if (curValid && (curOp == opRefill)) begin
        dirValid[curIndex] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in.valid) begin
      curOp <= in.op;
      curIndex <= in.index;
      curHalf <= in.half;
      curTag <= in.tag;
      curUser <= in.user;
      curWrite <= in.write;
      curPaged <= in.paged;
      curLine <= in.line;
      curParForce <= in.parForce;
    end
  end

  // Table write on refill, synchronous read on index
  always_ff @(posedge clk) begin
    if (curValid && (curOp == opRefill)) begin
      ptMem[curIndex] <= curLine;
      tagMem[curIndex] <= curTag;
      parMem[curIndex] <= parNext;
    end
    rdLine <= ptMem[curIndex];
    rdTag <= tagMem[curIndex];
    rdPar <= parMem[curIndex];
    rdDirValid <= dirValid[curIndex];
    rdReqTag <= curTag;
    rdHalf <= curHalf;
    rdUser <= curUser;
    rdWrite <= curWrite;
    rdPaged <= curPaged;
    rdVpnLow <= vpnLowNext;
  end

  assign selHalf = rdHalf ? rdLine.right : rdLine.left;
  assign selPar = rdHalf ? rdPar[0] : rdPar[1];

  assign out.valid = rdValid;
  assign out.hit = rdDirValid && (rdTag == rdReqTag);
  assign out.entry = selHalf;
  assign out.parOk = ^{selHalf, selPar};
  assign out.user = rdUser;
  assign out.write = rdWrite;
  assign out.paged = rdPaged;
  assign out.vpnLow = rdVpnLow;

endmodule

// ==== hw/ptReqIf.sv ====
`timescale 1ns/1ps
interface ptReqIf;
  import pagerPkg::*;

  logic valid;
  ptOpT op;
  logic [ptIdxW-1:0] index;
  // Right half when set
  logic half;
  logic [tagW-1:0] tag;
  logic user;
  logic write;
  logic paged;
  // Refill data, both halves
  ptLineT line;
  logic parForce;

  modport src (
    output valid, op, index, half, tag,
    output user, write, paged,
    output line, parForce
  );

  modport dst (
    input valid, op, index, half, tag,
    input user, write, paged,
    input line, parForce
  );

endinterface

// ==== hw/ptRspIf.sv ====
`timescale 1ns/1ps
interface ptRspIf;
  import pagerPkg::*;

  logic valid;
  logic hit;
  // Selected half of the line
  ptHalfT entry;
  logic parOk;
  logic user;
  logic write;
  logic paged;
  logic [ppnW-1:0] vpnLow;

  modport src (
    output valid, hit, entry, parOk,
    output user, write, paged, vpnLow
  );

  modport dst (
    input valid, hit, entry, parOk,
    input user, write, paged, vpnLow
  );

endinterface

// ==== list.f ====
hw/pagerPkg.sv
hw/ptReqIf.sv
hw/ptRspIf.sv
hw/ptIndex.sv
hw/ptLookup.sv
hw/accessCheck.sv
hw/pager.sv
tests/pager_assertions.sv
tests/pagerTb.sv

// ==== tests/pagerTb.sv ====
`timescale 1ns/1ps
module pagerTb;
  import pagerPkg::*;

  localparam int rspTimeout = 20;
  localparam int randCount = 16;

  logic clk = 1'b0;
  logic rstN;
  logic reqValid;
  ptOpT reqOp;
  logic [vpnW-1:0] vpn;
  logic user;
  logic write;
  logic paged;
  ptLineT refillLine;
  logic parForce;
  logic rspValid;
  logic pageOk;
  logic pageRefill;
  logic pageFail;
  pfCodeT failCode;
  logic [ppnW-1:0] physPage;
  logic cacheable;

  int edgeCount = 0;
  int errorCount = 0;
  int failCount = 0;
  int testCount = 0;
  int passCount = 0;
  logic [31:0] randState = 32'h20c8;

  // Expected lookups in issue order
  string expName [$];
  int expOutcome [$];
  int expCode [$];
  int expPage [$];
  int expCache [$];
  int expEdge [$];

  // Outcome packed as {pageFail, pageRefill, pageOk}
  logic [31:0] gotOutcome [$];
  logic [31:0] gotCode [$];
  logic [31:0] gotPage [$];
  logic [31:0] gotCache [$];
  logic [31:0] gotEdge [$];

  pager u_dut (.*);

  always #5 clk = ~clk;

  always @(posedge clk) begin
    edgeCount <= edgeCount + 1;
  end

  always @(negedge clk) begin
    if (rstN && rspValid) begin
      gotOutcome.push_back({29'd0, pageFail, pageRefill, pageOk});
      gotCode.push_back({29'd0, failCode});
      gotPage.push_back({19'd0, physPage});
      gotCache.push_back({31'd0, cacheable});
      gotEdge.push_back(edgeCount);
    end
  end

  function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic checkValue(input string testName, input string field,
                            input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %0s %0s: expected %0h, actual %0h", testName, field, expected, actual);
      errorCount++;
    end
  endtask

  task automatic issueOp(input logic [1:0] opBits, input logic [vpnW-1:0] addr,
                         input logic isUser, input logic isWrite, input logic isPaged,
                         input ptLineT lineData, input logic parBit);
    @(posedge clk);
    #1;
    reqValid = 1'b1;
    reqOp = ptOpT'(opBits);
    vpn = addr;
    user = isUser;
    write = isWrite;
    paged = isPaged;
    refillLine = lineData;
    parForce = parBit;
  endtask

  // Request is sampled at the edge after issueOp drives it
  task automatic expectResult(input string testName, input int outcome, input int code,
                              input int page, input int cache);
    expName.push_back(testName);
    expOutcome.push_back(outcome);
    expCode.push_back(code);
    expPage.push_back(page);
    expCache.push_back(cache);
    expEdge.push_back(edgeCount + 1);
  endtask

  initial begin
    int fd;
    int nItems;
    int opVal, vpnVal, userVal, writeVal, pagedVal, leftVal, rightVal, parVal;
    int outVal, codeVal, pageVal, cacheVal;
    int waitCycles;
    int rdPtr;
    int errBefore;
    bit timedOut;
    string lineText;
    string testName;
    logic [vpnW-1:0] randVpn;

    rstN = 1'b0;
    reqValid = 1'b0;
    reqOp = opLookup;
    vpn = '0;
    user = 1'b0;
    write = 1'b0;
    paged = 1'b0;
    refillLine = '0;
    parForce = 1'b0;
    timedOut = 1'b0;
    rdPtr = 0;
    repeat (2) @(posedge clk);
    #1;
    rstN = 1'b1;

    fd = $fopen("tests/pager_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open tests/pager_testdata.txt");
      failCount++;
    end else begin
      while (!$feof(fd)) begin
        lineText = "";
        void'($fgets(lineText, fd));
        if (lineText.len() > 0 && lineText.getc(0) != "#") begin
          nItems = $sscanf(lineText, "%s %h %h %h %h %h %h %h %h %h %h %h %h", testName,
                           opVal, vpnVal, userVal, writeVal, pagedVal, leftVal, rightVal,
                           parVal, outVal, codeVal, pageVal, cacheVal);
          if (nItems == 13) begin
            issueOp(opVal[1:0], vpnVal[13:0], userVal[0], writeVal[0], pagedVal[0],
                    {leftVal[17:0], rightVal[17:0]}, parVal[0]);
            if (opVal == 0) begin
              expectResult(testName, outVal, codeVal, pageVal, cacheVal);
            end
          end else if (nItems > 0) begin
            $display("Malformed line in test data: %0s", lineText);
            failCount++;
          end
        end
      end
      $fclose(fd);
    end

    // Unpaged burst of one lookup per cycle
    for (int i = 0; i < randCount; i++) begin
      randState = lcgNext(randState);
      randVpn = randState[29:16];
      issueOp(2'd0, randVpn, randState[9], randState[13], 1'b0, '0, 1'b0);
      expectResult($sformatf("random%0d", i), 1, 0, int'(randVpn[12:0]), 0);
    end
    @(posedge clk);
    #1;
    reqValid = 1'b0;

    for (int i = 0; i < expName.size(); i++) begin
      if (!timedOut) begin
        waitCycles = 0;
        while (gotOutcome.size() <= rdPtr && waitCycles < rspTimeout) begin
          @(posedge clk);
          waitCycles++;
        end
        if (gotOutcome.size() <= rdPtr) begin
          $display("No response for %0s within %0d cycles", expName[i], rspTimeout);
          timedOut = 1'b1;
          failCount++;
        end else begin
          errBefore = errorCount;
          checkValue(expName[i], "outcome", expOutcome[i], gotOutcome[rdPtr]);
          checkValue(expName[i], "failCode", expCode[i], gotCode[rdPtr]);
          if (expOutcome[i] == 1) begin
            checkValue(expName[i], "physPage", expPage[i], gotPage[rdPtr]);
            checkValue(expName[i], "cacheable", expCache[i], gotCache[rdPtr]);
          end
          checkValue(expName[i], "latency", expEdge[i] + 3, gotEdge[rdPtr]);
          testCount++;
          if (errorCount == errBefore) begin
            passCount++;
            $display("%0s: ok", expName[i]);
          end else begin
            $display("%0s: mismatch", expName[i]);
          end
          rdPtr++;
        end
      end
    end

    repeat (5) @(posedge clk);
    if (!timedOut && gotOutcome.size() > rdPtr) begin
      $display("DUT gave %0d responses that no lookup asked for", gotOutcome.size() - rdPtr);
      failCount++;
    end
    if (testCount == 0) begin
      $display("No lookup was checked");
      failCount++;
    end
    if (u_dut.uAssertions.failures != 0) begin
      $display("Pipeline assertions failed %0d times", u_dut.uAssertions.failures);
      failCount++;
    end

    $display("%0d tests, %0d passed, %0d failed, %0d other errors", testCount, passCount,
             testCount - passCount, failCount);
    if (errorCount == 0 && failCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== tests/pager_assertions.sv ====
`timescale 1ns/1ps
module pagerAssertions (
  input logic           clk,
  input logic           rstN,
  input logic           reqValid,
  input pagerPkg::ptOpT reqOp,
  input logic           rspValid,
  input logic           pageOk,
  input logic           pageRefill,
  input logic           pageFail
);
  import pagerPkg::*;

  int failures = 0;

  outcomeOneHot: assert property (@(posedge clk) disable iff (!rstN)
    $onehot0({pageOk, pageRefill, pageFail}))
    else begin
      $error("More than one outcome set in the same cycle");
      failures++;
    end

  outcomeNeedsValid: assert property (@(posedge clk) disable iff (!rstN)
    (pageOk || pageRefill || pageFail) |-> rspValid)
    else begin
      $error("Outcome set without rspValid");
      failures++;
    end

  // Request sampled four edges before the response is seen
  rspFromLookup: assert property (@(posedge clk) disable iff (!rstN)
    rspValid |-> $past(reqValid && (reqOp == opLookup), 4))
    else begin
      $error("rspValid without a lookup three cycles earlier");
      failures++;
    end

  lookupGivesRsp: assert property (@(posedge clk) disable iff (!rstN)
    $past(reqValid && (reqOp == opLookup), 4) |-> rspValid)
    else begin
      $error("Lookup gave no response after three cycles");
      failures++;
    end

endmodule

bind pager pagerAssertions uAssertions (
  .clk        (clk),
  .rstN       (rstN),
  .reqValid   (reqValid),
  .reqOp      (reqOp),
  .rspValid   (rspValid),
  .pageOk     (pageOk),
  .pageRefill (pageRefill),
  .pageFail   (pageFail)
);

// ==== tests/pager_testdata.txt ====
# name op vpn user write paged left right parForce outcome failCode physPage cache (all hex)
# op 0 lookup 1 refill 2 dirClr; outcome 1 ok 2 refill 4 fail 0 none
resetMiss      0 0040 0 0 1 00000 00000 0 2 0 0000 0
refillExec     1 0040 0 0 1 3a123 38456 0 0 0 0000 0
evenHit        0 0040 0 0 1 00000 00000 0 1 0 0123 1
oddHit         0 0041 0 0 1 00000 00000 0 1 0 0456 0
userMiss       0 0040 1 0 1 00000 00000 0 2 0 0000 0
refillUser     1 0200 1 0 1 3a777 38888 0 0 0 0000 0
userHit        0 0200 1 0 1 00000 00000 0 1 0 0777 1
execOtherLine  0 0200 0 0 1 00000 00000 0 2 0 0000 0
execTagMiss    0 0280 0 0 1 00000 00000 0 2 0 0000 0
refillPerm     1 0004 1 0 1 00111 20222 0 0 0 0000 0
noAccess       0 0004 1 1 1 00000 00000 0 4 2 0000 0
privOverWp     0 0005 1 1 1 00000 00000 0 4 3 0000 0
refillRo       1 0006 0 0 1 30333 3a444 0 0 0 0000 0
writeProt      0 0006 0 1 1 00000 00000 0 4 4 0000 0
readOnlyOk     0 0006 0 0 1 00000 00000 0 1 0 0333 0
writeOk        0 0007 0 1 1 00000 00000 0 1 0 0444 1
refillBadPar   1 0008 0 0 1 1e555 3a666 1 0 0 0000 0
parNoAccess    0 0008 0 0 1 00000 00000 0 4 1 0000 0
parOdd         0 0009 0 0 1 00000 00000 0 4 1 0000 0
unpaged        0 0008 0 0 0 00000 00000 0 1 0 0008 0
dirClear       2 0000 0 0 0 00000 00000 0 0 0 0000 0
clrMiss        0 0040 0 0 1 00000 00000 0 2 0 0000 0
clrMissRo      0 0006 0 0 1 00000 00000 0 2 0 0000 0
refillAgain    1 0040 0 0 1 3b9ab 39fff 0 0 0 0000 0
againEven      0 0040 0 0 1 00000 00000 0 1 0 19ab 1
againOdd       0 0041 0 0 1 00000 00000 0 1 0 1fff 0
